// File: Bender.yml
package:
  name: conv_engine

sources:
  # RTL in compile order
  - files:
      - logic/conv_pkg.sv
      - logic/conv_beat_skid.sv
      - logic/conv_mac_array.sv
      - logic/conv_sum_drain.sv
      - logic/conv_engine.sv

  # testbench, top module conv_engine_tb
  - target: test
    files:
      - verification/conv_engine_tb.sv

// File: logic/conv_beat_skid.sv
// registered input side, the source must hold s_pixels, s_weights and s_last steady while stalled
`timescale 1ns/100ps

module conv_beat_skid import conv_pkg::*; #(
  parameter int UNITS   = 4,
  parameter int MEMBERS = 3
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          s_valid,
  output logic                          s_ready,
  input  logic                          s_last,
  input  logic [UNITS*WORD_WIDTH-1:0]   s_pixels,
  input  logic [MEMBERS*WORD_WIDTH-1:0] s_weights,
  output logic                          beat_valid,
  input  logic                          beat_ready,
  output logic                          beat_last,
  output logic [UNITS*WORD_WIDTH-1:0]   beat_pixels,
  output logic [MEMBERS*WORD_WIDTH-1:0] beat_weights
);

  logic                          spare_valid;
  logic                          spare_last;
  logic [UNITS*WORD_WIDTH-1:0]   spare_pixels;
  logic [MEMBERS*WORD_WIDTH-1:0] spare_weights;

  logic accept_in;
  logic main_free;

  assign accept_in = s_valid && s_ready;
  assign main_free = !beat_valid || beat_ready;  // main empties or hands off this cycle

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beat_valid  <= 1'b0;
      spare_valid <= 1'b0;
      s_ready     <= 1'b1;
    end else if (main_free) begin
      if (spare_valid) begin
        beat_valid  <= 1'b1;  // spare moves up, input is blocked meanwhile
        spare_valid <= 1'b0;
        s_ready     <= 1'b1;
      end else begin
        beat_valid <= accept_in;
      end
    end else if (accept_in) begin
      spare_valid <= 1'b1;  // beat in flight lands in the spare
      s_ready     <= 1'b0;  // both entries full
    end
  end

  always_ff @(posedge clk) begin
    if (main_free) begin
      if (spare_valid) begin
        beat_last    <= spare_last;
        beat_pixels  <= spare_pixels;
        beat_weights <= spare_weights;
      end else begin
        beat_last    <= s_last;
        beat_pixels  <= s_pixels;
        beat_weights <= s_weights;
      end
    end
    if (accept_in && !main_free) begin
      spare_last    <= s_last;
      spare_pixels  <= s_pixels;
      spare_weights <= s_weights;
    end
  end

endmodule

// File: logic/conv_engine.sv
// conv engine top, pixels and weights are packed word 0 low and output words leave member-major
`timescale 1ns/100ps

module conv_engine import conv_pkg::*; #(
  parameter int UNITS   = 4,
  parameter int MEMBERS = 3
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          s_valid,
  output logic                          s_ready,
  input  logic                          s_last,
  input  logic [UNITS*WORD_WIDTH-1:0]   s_pixels,
  input  logic [MEMBERS*WORD_WIDTH-1:0] s_weights,
  output logic                          m_valid,
  input  logic                          m_ready,
  output acc_t                          m_data,
  output logic                          m_last
);

  logic                               beat_valid;
  logic                               beat_ready;
  logic                               beat_last;
  logic [UNITS*WORD_WIDTH-1:0]        beat_pixels;
  logic [MEMBERS*WORD_WIDTH-1:0]      beat_weights;
  logic                               sum_valid;
  logic                               sum_ready;
  logic [MEMBERS*UNITS*ACC_WIDTH-1:0] sums;

  conv_beat_skid #(.UNITS(UNITS), .MEMBERS(MEMBERS)) skid_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .s_valid      (s_valid),
    .s_ready      (s_ready),
    .s_last       (s_last),
    .s_pixels     (s_pixels),
    .s_weights    (s_weights),
    .beat_valid   (beat_valid),
    .beat_ready   (beat_ready),
    .beat_last    (beat_last),
    .beat_pixels  (beat_pixels),
    .beat_weights (beat_weights)
  );

  conv_mac_array #(.UNITS(UNITS), .MEMBERS(MEMBERS)) mac_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .beat_valid   (beat_valid),
    .beat_ready   (beat_ready),
    .beat_last    (beat_last),
    .beat_pixels  (beat_pixels),
    .beat_weights (beat_weights),
    .sum_valid    (sum_valid),
    .sum_ready    (sum_ready),
    .sums         (sums)
  );

  conv_sum_drain #(.UNITS(UNITS), .MEMBERS(MEMBERS)) drain_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .sum_valid (sum_valid),
    .sum_ready (sum_ready),
    .sums      (sums),
    .m_valid   (m_valid),
    .m_ready   (m_ready),
    .m_data    (m_data),
    .m_last    (m_last)
  );

endmodule

// File: logic/conv_mac_array.sv
// multiply and accumulate grid, a block runs until the beat with beat_last and sums wrap at ACC_WIDTH
`timescale 1ns/100ps

module conv_mac_array import conv_pkg::*; #(
  parameter int UNITS   = 4,
  parameter int MEMBERS = 3
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 beat_valid,
  output logic                                 beat_ready,
  input  logic                                 beat_last,
  input  logic [UNITS*WORD_WIDTH-1:0]          beat_pixels,
  input  logic [MEMBERS*WORD_WIDTH-1:0]        beat_weights,
  output logic                                 sum_valid,
  input  logic                                 sum_ready,
  output logic [MEMBERS*UNITS*ACC_WIDTH-1:0]   sums
);

  logic beat_accept;
  logic first_q;    // next accepted beat opens a block
  logic tag_valid;  // product stage holds a beat
  logic tag_first;
  logic tag_last;
  logic bank_load;
  logic bank_busy;

  word_t pixel  [UNITS];
  word_t weight [MEMBERS];

  // a new last beat must not reach the bank while an earlier array still sits there
  assign bank_busy   = (sum_valid && !sum_ready) || (tag_valid && tag_last);
  assign beat_ready  = !(beat_valid && beat_last && bank_busy);
  assign beat_accept = beat_valid && beat_ready;
  assign bank_load   = tag_valid && tag_last;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      first_q   <= 1'b1;
      tag_valid <= 1'b0;
      tag_first <= 1'b0;
      tag_last  <= 1'b0;
    end else begin
      tag_valid <= beat_accept;
      if (beat_accept) begin
        first_q   <= beat_last;  // the beat after a last one starts fresh
        tag_first <= first_q;
        tag_last  <= beat_last;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum_valid <= 1'b0;
    end else if (bank_load) begin
      sum_valid <= 1'b1;
    end else if (sum_ready) begin
      sum_valid <= 1'b0;
    end
  end

  for (genvar u = 0; u < UNITS; u++) begin : g_pixel
    assign pixel[u] = beat_pixels[u*WORD_WIDTH +: WORD_WIDTH];
  end

  for (genvar m = 0; m < MEMBERS; m++) begin : g_weight
    assign weight[m] = beat_weights[m*WORD_WIDTH +: WORD_WIDTH];
  end

  for (genvar m = 0; m < MEMBERS; m++) begin : g_member
    for (genvar u = 0; u < UNITS; u++) begin : g_unit
      prod_t prod_q;
      acc_t  acc_q;
      acc_t  acc_next;
      acc_t  bank_q;

      always_ff @(posedge clk) begin
        if (beat_accept) begin
          prod_q <= weight[m] * pixel[u];  // signed 8x8
        end
      end

      // load on the first beat of a block, add otherwise
      assign acc_next = tag_first ? acc_t'(prod_q) : acc_q + acc_t'(prod_q);

      always_ff @(posedge clk) begin
        if (tag_valid) begin
          acc_q <= acc_next;
        end
        if (bank_load) begin
          bank_q <= acc_next;  // takes the final sum, grid is free again
        end
      end

      assign sums[(m*UNITS+u)*ACC_WIDTH +: ACC_WIDTH] = bank_q;  // member-major
    end
  end

endmodule

// File: logic/conv_pkg.sv
// shared widths and types for the conv engine, sums are 24-bit two's complement and wrap on overflow
package conv_pkg;

  localparam int WORD_WIDTH = 8;   // one pixel or one weight
  localparam int ACC_WIDTH  = 24;  // one accumulated sum

  // signed pixel or weight
  typedef logic signed [WORD_WIDTH-1:0]   word_t;

  // full-precision product of two words
  typedef logic signed [2*WORD_WIDTH-1:0] prod_t;

  // accumulated sum, wraps modulo 2^ACC_WIDTH
  typedef logic signed [ACC_WIDTH-1:0]    acc_t;

  // output side state
  typedef enum logic [0:0] {
    DRAIN_IDLE = 1'b0,  // waiting for a finished sum array
    DRAIN_SEND = 1'b1   // serializing the held array
  } drain_state_t;

endpackage

// File: logic/conv_sum_drain.sv
// serializes one finished sum array in member-major order, a new array is taken only after the last word
`timescale 1ns/100ps

module conv_sum_drain import conv_pkg::*; #(
  parameter int UNITS   = 4,
  parameter int MEMBERS = 3
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               sum_valid,
  output logic                               sum_ready,
  input  logic [MEMBERS*UNITS*ACC_WIDTH-1:0] sums,
  output logic                               m_valid,
  input  logic                               m_ready,
  output acc_t                               m_data,
  output logic                               m_last
);

  localparam int WORDS = MEMBERS * UNITS;
  localparam int IDX_W = (WORDS > 1) ? $clog2(WORDS) : 1;

  drain_state_t state;
  logic [IDX_W-1:0] idx;
  logic [WORDS*ACC_WIDTH-1:0] bank;
  logic final_word;
  logic take;

  assign take       = (state == DRAIN_IDLE) && sum_valid;
  assign final_word = (idx == IDX_W'(WORDS - 1));

  assign sum_ready = (state == DRAIN_IDLE);
  assign m_valid   = (state == DRAIN_SEND);
  assign m_last    = m_valid && final_word;
  assign m_data    = acc_t'(bank[idx*ACC_WIDTH +: ACC_WIDTH]);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= DRAIN_IDLE;
      idx   <= '0;
    end else begin
      case (state)
        DRAIN_IDLE: begin
          if (sum_valid) begin
            state <= DRAIN_SEND;
            idx   <= '0;
          end
        end
        DRAIN_SEND: begin
          if (m_ready) begin
            if (final_word) begin
              state <= DRAIN_IDLE;
            end else begin
              idx <= idx + 1'b1;  // one word per accepted beat
            end
          end
        end
        default: state <= DRAIN_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      bank <= sums;  // frees the MAC output bank right away
    end
  end

endmodule

// File: tb.f
logic/conv_pkg.sv
logic/conv_beat_skid.sv
logic/conv_mac_array.sv
logic/conv_sum_drain.sv
logic/conv_engine.sv
verification/conv_engine_tb.sv

// File: verification/conv_engine_tb.sv
// testbench for conv_engine with UNITS=4 and MEMBERS=3 on seed 81 with blocks of 1 to 16 beats
`timescale 1ns/100ps

module conv_engine_tb import conv_pkg::*;;

  localparam int UNITS   = 4;
  localparam int MEMBERS = 3;
  localparam int WORDS   = MEMBERS * UNITS;
  localparam int MAX_LEN = 16;
  // upper bound of beats and blocks over all five tests
  localparam int RUN_BEATS   = 1 + 8*MAX_LEN + 4*MAX_LEN + 12*3 + 40*MAX_LEN;
  localparam int RUN_BLOCKS  = 1 + 8 + 4 + 12 + 40;
  localparam int CYCLE_LIMIT = 20 * (RUN_BEATS + RUN_BLOCKS*WORDS);

  logic                          clk;
  logic                          rst_n;
  logic                          s_valid;
  logic                          s_ready;
  logic                          s_last;
  logic [UNITS*WORD_WIDTH-1:0]   s_pixels;
  logic [MEMBERS*WORD_WIDTH-1:0] s_weights;
  logic                          m_valid;
  logic                          m_ready;
  acc_t                          m_data;
  logic                          m_last;

  word_t blk_pix [MAX_LEN][UNITS];  // beats of the block being sent
  word_t blk_wt  [MAX_LEN][MEMBERS];
  acc_t  exp_q [$];
  int    ready_pct;
  int    errors, tests_passed, tests_failed;
  int    blocks_sent, last_count, words_seen, out_idx, stall_cycles, cycles;

  conv_engine #(.UNITS(UNITS), .MEMBERS(MEMBERS)) dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .s_valid   (s_valid),
    .s_ready   (s_ready),
    .s_last    (s_last),
    .s_pixels  (s_pixels),
    .s_weights (s_weights),
    .m_valid   (m_valid),
    .m_ready   (m_ready),
    .m_data    (m_data),
    .m_last    (m_last)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // expected member-major words of the stored block wrapped to ACC_WIDTH
  function automatic logic [WORDS*ACC_WIDTH-1:0] compute_sums(input int nbeats);
    logic [WORDS*ACC_WIDTH-1:0] res;
    int acc;
    res = '0;
    for (int m = 0; m < MEMBERS; m++) begin
      for (int u = 0; u < UNITS; u++) begin
        acc = 0;
        for (int b = 0; b < nbeats; b++) begin
          acc += int'(blk_wt[b][m]) * int'(blk_pix[b][u]);
        end
        res[(m*UNITS+u)*ACC_WIDTH +: ACC_WIDTH] = acc[ACC_WIDTH-1:0];
      end
    end
    return res;
  endfunction

  task automatic check_value(input string name, input logic signed [63:0] got,
                             input logic signed [63:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  function automatic word_t pick_word(input int edge_pct);
    if ($urandom_range(99, 0) < edge_pct) begin
      return ($urandom_range(1, 0) != 0) ? word_t'(-128) : word_t'(127);
    end
    return word_t'($urandom_range(255, 0));
  endfunction

  task automatic fill_block(input int nbeats, input int edge_pct);
    for (int b = 0; b < nbeats; b++) begin
      for (int u = 0; u < UNITS; u++) blk_pix[b][u] = pick_word(edge_pct);
      for (int m = 0; m < MEMBERS; m++) blk_wt[b][m] = pick_word(edge_pct);
    end
  endtask

  // called and returns at 1 ns after a rising edge
  task automatic send_block(input int nbeats, input int gap_pct);
    logic [WORDS*ACC_WIDTH-1:0] expect_words;
    bit took;
    expect_words = compute_sums(nbeats);
    for (int i = 0; i < WORDS; i++) begin
      exp_q.push_back(acc_t'(expect_words[i*ACC_WIDTH +: ACC_WIDTH]));
    end
    blocks_sent++;
    for (int b = 0; b < nbeats; b++) begin
      if (gap_pct > 0 && $urandom_range(99, 0) < gap_pct) begin
        s_valid = 1'b0;
        repeat ($urandom_range(3, 1)) begin
          @(posedge clk);
        end
        #1;
      end
      for (int u = 0; u < UNITS; u++) s_pixels[u*WORD_WIDTH +: WORD_WIDTH] = blk_pix[b][u];
      for (int m = 0; m < MEMBERS; m++) s_weights[m*WORD_WIDTH +: WORD_WIDTH] = blk_wt[b][m];
      s_last  = (b == nbeats - 1);
      s_valid = 1'b1;
      do begin
        took = s_ready;  // registered so it holds until the next edge
        @(posedge clk);
        #1;
      end while (!took);
    end
    s_valid = 1'b0;
    s_last  = 1'b0;
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) @(posedge clk);
    repeat (2) @(posedge clk);
    #1;
  endtask

  task automatic end_test(input string name, input int errs_before);
    if (errors == errs_before) begin
      $display("test %s: pass", name);
      tests_passed++;
    end else begin
      $display("test %s: FAIL with %0d errors", name, errors - errs_before);
      tests_failed++;
    end
  endtask

  // random back-pressure on the output side
  initial begin
    forever begin
      @(posedge clk);
      #1;
      m_ready = ($urandom_range(99, 0) < ready_pct);
    end
  end

  // outputs are sampled at the falling edge while stable
  always @(negedge clk) begin
    if (rst_n) begin
      if (!s_ready) stall_cycles++;
      if (m_valid && m_ready) begin
        if (exp_q.size() == 0) begin
          $display("ERROR at %0t: output word %0d arrived with no expected block queued",
                   $time, m_data);
          errors++;
        end else begin
          check_value("m_data", m_data, exp_q.pop_front());
          check_value("m_last", m_last, out_idx == WORDS - 1);
        end
        if (m_last) last_count++;
        out_idx = (out_idx == WORDS - 1) ? 0 : out_idx + 1;
        words_seen++;
      end
    end
  end

  initial begin
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
        $display("timeout after %0d cycles with %0d expected words still queued",
                 cycles, exp_q.size());
        $display("Result: FAILED");
        $finish;
      end
    end
  end

  initial begin
    int errs;
    int len;
    void'($urandom(81));
    rst_n = 1'b0;
    s_valid = 1'b0;
    s_last = 1'b0;
    s_pixels = '0;
    s_weights = '0;
    m_ready = 1'b1;
    ready_pct = 100;
    errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    blocks_sent = 0;
    last_count = 0;
    words_seen = 0;
    out_idx = 0;
    stall_cycles = 0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    errs = errors;  // single beat gives the plain products
    repeat (8) begin
      check_value("s_ready", s_ready, 1);
      check_value("m_valid", m_valid, 0);
      @(posedge clk);
      #1;
    end
    for (int u = 0; u < UNITS; u++) blk_pix[0][u] = word_t'(u + 1);
    for (int m = 0; m < MEMBERS; m++) blk_wt[0][m] = word_t'(-2*m - 3);
    send_block(1, 0);
    wait_drained();
    end_test("single_beat", errs);

    errs = errors;
    for (int i = 0; i < 8; i++) begin
      len = $urandom_range(MAX_LEN, 2);
      fill_block(len, 25);
      if (i == 0) begin
        blk_pix[0][0] = word_t'(-128);
        blk_wt[0][0]  = word_t'(-128);
        blk_wt[0][1]  = word_t'(127);
      end
      send_block(len, 10);
    end
    wait_drained();
    end_test("multi_beat_signed", errs);

    errs = errors;  // s_valid stays high across block borders
    for (int i = 0; i < 4; i++) begin
      fill_block(MAX_LEN, (i == 0) ? 90 : 0);
      send_block($urandom_range(MAX_LEN, 2), 0);
    end
    wait_drained();
    end_test("back_to_back", errs);

    errs = errors;
    ready_pct = 30;
    stall_cycles = 0;
    for (int i = 0; i < 12; i++) begin
      fill_block(3, 10);
      send_block($urandom_range(3, 1), 20);
    end
    wait_drained();
    if (stall_cycles == 0) begin
      $display("ERROR: s_ready never fell while the output side was throttled");
      errors++;
    end
    end_test("back_pressure", errs);

    errs = errors;
    ready_pct = 70;
    for (int i = 0; i < 40; i++) begin
      fill_block(MAX_LEN, 10);
      send_block($urandom_range(MAX_LEN, 2), 25);
    end
    wait_drained();
    check_value("m_last count", last_count, blocks_sent);
    check_value("output words", words_seen, blocks_sent * WORDS);
    end_test("long_run", errs);

    $display("tests passed %0d, failed %0d, errors %0d, blocks %0d",
             tests_passed, tests_failed, errors, blocks_sent);
    if (errors == 0 && tests_failed == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
